//--- Bender.yml
package:
  name: rv32i_int_core

sources:
  - include_dirs:
      - .
    files:
      - rv32i_int_pkg.sv
      - rv32i_issue_if.sv
      - rv32i_decoder.sv
      - rv32i_regfile.sv
      - rv32i_execute.sv
      - rv32i_int_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv32i_int_core.sv

//--- rv32i_decoder.sv
////////////////////////////////////////
// instruction decoder and D stage registers
////////////////////////////////////////
`include "rv32i_int_cfg.svh"

module rv32i_decoder (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  rv32i_int_pkg::inst_t i_inst,       // instruction word
    input  logic                 i_inst_valid, // strobe
    rv32i_issue_if.decode        issue         // D stage outputs
);
    import rv32i_int_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    alu_op_c;
    logic       use_imm_c;
    word_t      imm_c;
    logic       illegal_c;

    // funct3 gives the same op for r and i forms, f7 picks sub/sra
    function automatic alu_op_t base_op(input logic [2:0] f3);
        alu_op_t op;
        case (f3)
            `F3_ADD_SUB: op = `ALU_ADD;
            `F3_SLL:     op = `ALU_SLL;
            `F3_SLT:     op = `ALU_SLT;
            `F3_SLTU:    op = `ALU_SLTU;
            `F3_XOR:     op = `ALU_XOR;
            `F3_SRL_SRA: op = `ALU_SRL;
            `F3_OR:      op = `ALU_OR;
            default:     op = `ALU_AND; // f3 111
        endcase
        return op;
    endfunction

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    always_comb begin
        alu_op_c  = base_op(funct3);
        use_imm_c = 1'b0;
        imm_c     = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]}; // i imm
        illegal_c = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                if (funct7 == `F7_ALT) begin
                    if (funct3 == `F3_ADD_SUB) begin
                        alu_op_c = `ALU_SUB;
                    end else if (funct3 == `F3_SRL_SRA) begin
                        alu_op_c = `ALU_SRA;
                    end else begin
                        illegal_c = 1'b1; // alt f7 only for sub/sra
                    end
                end else if (funct7 != `F7_BASE) begin
                    illegal_c = 1'b1;
                end
            end
            `OP_ITYPE: begin
                use_imm_c = 1'b1;
                if (funct3 == `F3_SLL) begin
                    illegal_c = (funct7 != `F7_BASE); // slli shamt is 5 bits
                end else if (funct3 == `F3_SRL_SRA) begin
                    if (funct7 == `F7_ALT) begin
                        alu_op_c = `ALU_SRA; // srai
                    end else if (funct7 != `F7_BASE) begin
                        illegal_c = 1'b1;
                    end
                end
            end
            `OP_LUI: begin
                alu_op_c  = `ALU_PASS_B;
                use_imm_c = 1'b1;
                imm_c     = {i_inst[31:12], {(`XLEN-20){1'b0}}}; // u imm
            end
            default: begin
                illegal_c = 1'b1; // anything outside the integer subset
            end
        endcase
    end

    ////////////////////////////////////////
    // D stage, loads every cycle
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            issue.valid   <= 1'b0;
            issue.illegal <= 1'b0;
            issue.wr_rd   <= 1'b0;
        end else begin
            issue.valid   <= i_inst_valid;
            issue.illegal <= illegal_c;
            issue.wr_rd   <= (i_inst[11:7] != '0); // x0 is never written
        end
    end

    always_ff @(posedge i_clk) begin
        issue.alu_op   <= alu_op_c;
        issue.use_imm  <= use_imm_c;
        issue.imm      <= imm_c;
        issue.rs1_addr <= i_inst[19:15];
        issue.rs2_addr <= i_inst[24:20];
        issue.rd_addr  <= i_inst[11:7];
    end

endmodule

//--- rv32i_execute.sv
////////////////////////////////////////
// operand forwarding, ALU, writeback register
////////////////////////////////////////
`include "rv32i_int_cfg.svh"

module rv32i_execute (
    input  logic                     i_clk,
    input  logic                     i_rst,
    rv32i_issue_if.exec              issue,        // D stage fields
    input  rv32i_int_pkg::word_t     i_rs1,        // regfile read data
    input  rv32i_int_pkg::word_t     i_rs2,
    output logic                     o_wb_valid,   // result written back
    output rv32i_int_pkg::reg_addr_t o_wb_rd_addr,
    output rv32i_int_pkg::word_t     o_wb_rd,
    output logic                     o_illegal     // one cycle pulse
);
    import rv32i_int_pkg::*;

    word_t      op_a;    // rs1 after forwarding
    word_t      rs2_fwd; // rs2 after forwarding
    word_t      op_b;    // rs2 or imm
    word_t      result;
    logic [4:0] shamt;

    ////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////

    // writeback reg holds the previous instruction, regfile has not seen it yet
    assign op_a = (o_wb_valid && (o_wb_rd_addr == issue.rs1_addr)) ? o_wb_rd : i_rs1;
    assign rs2_fwd = (o_wb_valid && (o_wb_rd_addr == issue.rs2_addr)) ? o_wb_rd : i_rs2;

    assign op_b  = issue.use_imm ? issue.imm : rs2_fwd;
    assign shamt = op_b[4:0]; // only low 5 bits shift

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb begin
        case (issue.alu_op)
            `ALU_ADD: begin
                result = op_a + op_b;
            end
            `ALU_SUB: begin
                result = op_a - op_b; // wraps
            end
            `ALU_SLL: begin
                result = op_a << shamt;
            end
            `ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            `ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
            end
            `ALU_XOR: begin
                result = op_a ^ op_b;
            end
            `ALU_SRL: begin
                result = op_a >> shamt;
            end
            `ALU_SRA: begin
                result = word_t'($signed(op_a) >>> shamt); // sign fill
            end
            `ALU_OR: begin
                result = op_a | op_b;
            end
            `ALU_AND: begin
                result = op_a & op_b;
            end
            `ALU_PASS_B: begin
                result = op_b; // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // writeback register
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_wb_valid <= issue.valid && issue.wr_rd && !issue.illegal;
            o_illegal  <= issue.valid && issue.illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue.valid) begin
            o_wb_rd_addr <= issue.rd_addr;
            o_wb_rd      <= result;
        end
    end

endmodule

//--- rv32i_int_cfg.svh
////////////////////////////////////////
// widths, opcodes, funct codes and ALU
// operation codes of the integer core
////////////////////////////////////////
`ifndef RV32I_INT_CFG_SVH
`define RV32I_INT_CFG_SVH

`define XLEN       32 // data word width
`define REG_ADDR_W 5  // register index width
`define NUM_REGS   32 // x0..x31
`define ALU_OP_W   4  // alu operation code width

`define OP_RTYPE 7'b0110011 // register-register ops
`define OP_ITYPE 7'b0010011 // register-immediate ops
`define OP_LUI   7'b0110111 // load upper immediate

`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F7_BASE    7'b0000000 // add, srl and the plain ops
`define F7_ALT     7'b0100000 // sub, sra

`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_SLL    4'd2
`define ALU_SLT    4'd3
`define ALU_SLTU   4'd4
`define ALU_XOR    4'd5
`define ALU_SRL    4'd6
`define ALU_SRA    4'd7
`define ALU_OR     4'd8
`define ALU_AND    4'd9
`define ALU_PASS_B 4'd10 // lui, result is operand b

`endif

//--- rv32i_int_core.sv
////////////////////////////////////////
// three stage RV32I integer core, top level
////////////////////////////////////////
module rv32i_int_core (
    input  logic                     i_clk,
    input  logic                     i_rst,        // sync, active high
    input  rv32i_int_pkg::inst_t     i_inst,
    input  logic                     i_inst_valid, // one inst per high cycle
    output logic                     o_wb_valid,
    output rv32i_int_pkg::reg_addr_t o_wb_rd_addr,
    output rv32i_int_pkg::word_t     o_wb_rd,
    output logic                     o_illegal
);
    import rv32i_int_pkg::*;

    word_t rs1; // regfile reads, aligned with the D stage
    word_t rs2;

    rv32i_issue_if issue_bus ();

    ////////////////////////////////////////
    // D stage, decode and regfile in parallel
    ////////////////////////////////////////
    rv32i_decoder u_decoder (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst       (i_inst),
        .i_inst_valid (i_inst_valid),
        .issue        (issue_bus.decode)
    );

    rv32i_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_inst    (i_inst),
        .i_wr      (o_wb_valid),   // write port fed from writeback
        .i_rd_addr (o_wb_rd_addr),
        .i_rd      (o_wb_rd),
        .o_rs1     (rs1),
        .o_rs2     (rs2)
    );

    ////////////////////////////////////////
    // E stage and writeback
    ////////////////////////////////////////
    rv32i_execute u_execute (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .issue        (issue_bus.exec),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd_addr (o_wb_rd_addr),
        .o_wb_rd      (o_wb_rd),
        .o_illegal    (o_illegal)
    );

endmodule

//--- rv32i_int_pkg.sv
////////////////////////////////////////
// vector types shared by the integer core
////////////////////////////////////////
`include "rv32i_int_cfg.svh"

package rv32i_int_pkg;

    ////////////////////////////////////////
    // data path
    ////////////////////////////////////////

    typedef logic [`XLEN-1:0] word_t; // register value, alu result

    typedef logic [31:0] inst_t; // fixed by the isa

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // x0..x31

    typedef logic [`ALU_OP_W-1:0] alu_op_t; // one of the ALU_* codes

endpackage

//--- rv32i_issue_if.sv
////////////////////////////////////////
// D stage fields, decoder to execute
////////////////////////////////////////
interface rv32i_issue_if;
    import rv32i_int_pkg::*;

    logic      valid;    // one cycle per decoded instruction
    alu_op_t   alu_op;   // operation for the alu
    logic      use_imm;  // operand b is imm, not rs2
    word_t     imm;      // sign extended i imm or u imm
    reg_addr_t rs1_addr; // source addresses for forwarding
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;  // destination
    logic      wr_rd;    // low for rd x0
    logic      illegal;  // no legal decode

    modport decode (
        output valid, alu_op, use_imm, imm,
        output rs1_addr, rs2_addr, rd_addr, wr_rd, illegal
    );

    modport exec (
        input valid, alu_op, use_imm, imm,
        input rs1_addr, rs2_addr, rd_addr, wr_rd, illegal
    );

endinterface

//--- rv32i_regfile.sv
////////////////////////////////////////
// 32 x XLEN register file, registered reads
////////////////////////////////////////
`include "rv32i_int_cfg.svh"

module rv32i_regfile (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  rv32i_int_pkg::inst_t     i_inst,    // source fields read here
    input  logic                     i_wr,      // writeback valid
    input  rv32i_int_pkg::reg_addr_t i_rd_addr, // writeback destination
    input  rv32i_int_pkg::word_t     i_rd,      // writeback value
    output rv32i_int_pkg::word_t     o_rs1,     // valid with the D stage
    output rv32i_int_pkg::word_t     o_rs2
);
    import rv32i_int_pkg::*;

    word_t     regs [`NUM_REGS];
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      wr_en;

    // x0 reads zero, a write on the same edge passes straight through
    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && (i_rd_addr == addr)) begin
            val = i_rd;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rs1_addr = i_inst[19:15];
    assign rs2_addr = i_inst[24:20];
    assign wr_en    = i_wr && (i_rd_addr != '0); // x0 stays zero

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_rd_addr] <= i_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rs1 <= read_port(rs1_addr); // side by side with decode
        o_rs2 <= read_port(rs2_addr);
    end

endmodule

//--- sources.f
+incdir+.
rv32i_int_pkg.sv
rv32i_issue_if.sv
rv32i_decoder.sv
rv32i_regfile.sv
rv32i_execute.sv
rv32i_int_core.sv
tb_rv32i_int_core.sv

//--- tb_rv32i_int_core.sv
////////////////////////////////////////
// testbench for the integer core, reference
// model, expected queue, compare tasks
////////////////////////////////////////
`include "rv32i_int_cfg.svh"

module tb_rv32i_int_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv32i_int_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int INST_BUDGET  = 21 + 12 + 47 + 6 + 9 + 40; // issue cycles per test, gaps included
    localparam int CYCLE_LIMIT  = RESET_CYCLES + INST_BUDGET + 100;

    typedef struct {
        int        due;  // cycle count at which the result is on the wb ports
        logic      wr;
        logic      ill;
        reg_addr_t rd;
        word_t     val;
    } exp_t;

    logic      i_clk;
    logic      i_rst;
    inst_t     i_inst;
    logic      i_inst_valid;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd_addr;
    word_t     o_wb_rd;
    logic      o_illegal;

    word_t model_regs [32]; // architectural state of the model
    exp_t  exp_q [$];
    exp_t  head;
    int    cycle = 0;
    int    errors = 0;
    int    n_checks = 0;
    int    n_tests = 0;
    int    err_start;

    rv32i_int_core u_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst       (i_inst),
        .i_inst_valid (i_inst_valid),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd_addr (o_wb_rd_addr),
        .o_wb_rd      (o_wb_rd),
        .o_illegal    (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk; // 8 ns period
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////
    // encoders and reference model
    ////////////////////////////////////////
    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic inst_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OP_ITYPE};
    endfunction

    function automatic inst_t enc_lui(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, `OP_LUI};
    endfunction

    // legal op on x0..x7, dense register reuse
    function automatic inst_t rand_inst();
        reg_addr_t   rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        rd  = reg_addr_t'(1 + $urandom % 7);
        f3  = 3'($urandom);
        imm = 12'($urandom);
        f7  = ((f3 == `F3_ADD_SUB || f3 == `F3_SRL_SRA) && $urandom % 2) ? `F7_ALT : `F7_BASE;
        case ($urandom % 4)
            0: return enc_lui(rd, 20'($urandom));
            1: return enc_r(f7, f3, rd, reg_addr_t'($urandom % 8), reg_addr_t'($urandom % 8));
            default: begin
                if (f3 == `F3_SLL) imm[11:5] = `F7_BASE;
                else if (f3 == `F3_SRL_SRA) imm[11:5] = f7;
                return enc_i(f3, rd, reg_addr_t'($urandom % 8), imm);
            end
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t      r;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b); // signs differ
            3'b011: r = word_t'(a < b);
            3'b100: r = a ^ b;
            3'b101: begin
                r = a >> sh;
                if (alt && a[31]) r = r | ~(word_t'('1) >> sh); // fill vacated bits
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic void ref_exec(input inst_t inst, output logic wr, output reg_addr_t rd,
                                     output word_t val, output logic ill);
        logic [6:0] f7;
        logic [2:0] f3;
        logic       alt;
        word_t      b;
        f7  = inst[31:25];
        f3  = inst[14:12];
        rd  = inst[11:7];
        alt = (f7 == `F7_ALT);
        b   = model_regs[inst[24:20]];
        ill = 1'b0;
        val = '0;
        case (inst[6:0])
            `OP_LUI: val = {inst[31:12], 12'h000};
            `OP_RTYPE: begin
                ill = !(f7 == `F7_BASE || (alt && (f3 == `F3_ADD_SUB || f3 == `F3_SRL_SRA)));
                val = alu_ref(f3, alt, model_regs[inst[19:15]], b);
            end
            `OP_ITYPE: begin
                b = {{20{inst[31]}}, inst[31:20]}; // sign extended imm
                if (f3 == `F3_SLL) ill = (f7 != `F7_BASE);
                else if (f3 == `F3_SRL_SRA) ill = !(f7 == `F7_BASE || alt);
                val = alu_ref(f3, alt && (f3 == `F3_SRL_SRA), model_regs[inst[19:15]], b);
            end
            default: ill = 1'b1;
        endcase
        wr = !ill && (rd != '0);
    endfunction

    ////////////////////////////////////////
    // compare tasks and checker
    ////////////////////////////////////////
    task automatic check_wb(input reg_addr_t exp_addr, input word_t exp_val);
        n_checks++;
        if (o_wb_valid !== 1'b1) begin
            errors++;
            $display("missing writeback to x%0d at %0t ns", exp_addr, $time);
        end else if (o_wb_rd_addr !== exp_addr || o_wb_rd !== exp_val) begin
            errors++;
            $display("** Error at %0t ns: wb x%0d = %h, expected x%0d = %h",
                     $time, o_wb_rd_addr, o_wb_rd, exp_addr, exp_val);
        end
    endtask

    task automatic check_no_wb();
        n_checks++;
        if (o_wb_valid !== 1'b0) begin
            errors++;
            $display("unexpected writeback to x%0d at %0t ns, nothing was due", o_wb_rd_addr, $time);
        end
    endtask

    task automatic check_illegal(input logic exp_ill);
        n_checks++;
        if (o_illegal !== exp_ill) begin
            errors++;
            $display("** Error at %0t ns: o_illegal = %b, expected %b", $time, o_illegal, exp_ill);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                head = exp_q.pop_front();
                check_illegal(head.ill);
                if (head.wr) check_wb(head.rd, head.val);
                else check_no_wb();
            end else begin
                check_illegal(1'b0);
                check_no_wb();
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic issue_inst(input inst_t inst);
        exp_t      e;
        logic      wr;
        logic      ill;
        reg_addr_t rd;
        word_t     val;
        ref_exec(inst, wr, rd, val, ill);
        e.due = cycle + 2; // sampled next edge, on the wb ports one edge later
        e.wr  = wr;
        e.ill = ill;
        e.rd  = rd;
        e.val = val;
        exp_q.push_back(e);
        if (wr) model_regs[rd] = val;
        i_inst       = inst;
        i_inst_valid = 1'b1;
        @(negedge i_clk);
    endtask

    task automatic idle_cycle();
        i_inst       = inst_t'($urandom); // garbage while not valid
        i_inst_valid = 1'b0;
        @(negedge i_clk);
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) idle_cycle();
        n_tests++;
        $display("test %0d %-20s %s, %0d errors", n_tests, name,
                 (errors == err_start) ? "ok" : "bad", errors - err_start);
        err_start = errors;
    endtask

    task automatic test_rtype();
        issue_inst(enc_lui(5'd1, 20'($urandom)));
        issue_inst(enc_i(`F3_OR, 5'd1, 5'd1, 12'($urandom)));
        issue_inst(enc_lui(5'd2, 20'($urandom) | 20'h80000)); // x2 negative
        issue_inst(enc_i(`F3_ADD_SUB, 5'd2, 5'd2, 12'($urandom)));
        issue_inst(enc_i(`F3_ADD_SUB, 5'd3, 5'd0, 12'($urandom)));
        issue_inst(enc_lui(5'd4, 20'($urandom) & 20'h7ffff)); // x4 positive
        issue_inst(enc_i(`F3_OR, 5'd4, 5'd4, 12'($urandom) & 12'h7ff));
        for (int i = 0; i < 8; i++) begin
            issue_inst(enc_r(`F7_BASE, 3'(i), reg_addr_t'(10 + i), 5'd1, 5'd2));
        end
        issue_inst(enc_r(`F7_ALT, `F3_ADD_SUB, 5'd18, 5'd0, 5'd1)); // wraps below zero
        issue_inst(enc_r(`F7_ALT, `F3_ADD_SUB, 5'd19, 5'd3, 5'd2));
        issue_inst(enc_r(`F7_BASE, `F3_SLT, 5'd20, 5'd2, 5'd4)); // neg vs pos
        issue_inst(enc_r(`F7_BASE, `F3_SLTU, 5'd21, 5'd2, 5'd4));
        issue_inst(enc_r(`F7_ALT, `F3_SRL_SRA, 5'd22, 5'd2, 5'd4));
        issue_inst(enc_r(`F7_BASE, `F3_SRL_SRA, 5'd23, 5'd2, 5'd4));
    endtask

    task automatic test_itype();
        for (int i = 0; i < 8; i++) begin
            if (i != 1 && i != 5) begin // shifts below
                issue_inst(enc_i(3'(i), reg_addr_t'(24 + i), reg_addr_t'(1 + i % 4),
                                 12'($urandom) | 12'h800));
            end
        end
        for (int s = 0; s < 2; s++) begin
            issue_inst(enc_i(`F3_SLL, 5'd25, 5'd2, {`F7_BASE, 5'(s * 31)}));
            issue_inst(enc_i(`F3_SRL_SRA, 5'd26, 5'd2, {`F7_BASE, 5'(s * 31)}));
            issue_inst(enc_i(`F3_SRL_SRA, 5'd27, 5'd2, {`F7_ALT, 5'(s * 31)}));
        end
    endtask

    task automatic test_chains();
        reg_addr_t rd;
        for (int d = 1; d <= 3; d++) begin // dependency distance
            for (int i = 0; i < 9; i++) begin
                rd = reg_addr_t'(8 + i % d);
                if (i % 3 == 0) issue_inst(enc_i(`F3_ADD_SUB, rd, rd, 12'($urandom)));
                else issue_inst(enc_r(`F7_BASE, 3'($urandom), rd, rd, reg_addr_t'(8 + (i + 1) % d)));
            end
        end
        for (int i = 0; i < 20; i++) issue_inst(rand_inst());
    endtask

    task automatic test_x0();
        issue_inst(enc_i(`F3_ADD_SUB, 5'd0, 5'd1, 12'd123));
        issue_inst(enc_r(`F7_BASE, `F3_ADD_SUB, 5'd0, 5'd1, 5'd2));
        issue_inst(enc_lui(5'd0, 20'($urandom)));
        issue_inst(enc_r(`F7_BASE, `F3_ADD_SUB, 5'd28, 5'd0, 5'd0)); // x0 must read zero
        issue_inst(enc_r(`F7_BASE, `F3_OR, 5'd29, 5'd0, 5'd1));
        issue_inst(enc_i(`F3_ADD_SUB, 5'd30, 5'd0, 12'hfff));
    endtask

    task automatic test_illegal();
        issue_inst(enc_i(`F3_ADD_SUB, 5'd23, 5'd0, 12'd5));
        issue_inst({12'h000, 5'd0, 3'b010, 5'd23, 7'b0000011}); // load
        issue_inst(enc_i(`F3_ADD_SUB, 5'd23, 5'd23, 12'd1));
        issue_inst(enc_r(`F7_ALT, `F3_SLL, 5'd23, 5'd23, 5'd23));
        issue_inst(enc_r(7'b0000001, `F3_ADD_SUB, 5'd23, 5'd23, 5'd23)); // mul
        issue_inst(enc_i(`F3_SLL, 5'd23, 5'd23, {`F7_ALT, 5'd3}));
        issue_inst(enc_i(`F3_SRL_SRA, 5'd23, 5'd23, {7'b0000001, 5'd3}));
        issue_inst({20'h00010, 5'd23, 7'b1101111}); // jal
        issue_inst(enc_r(`F7_BASE, `F3_ADD_SUB, 5'd24, 5'd23, 5'd23));
    endtask

    task automatic test_gaps();
        for (int i = 0; i < 40; i++) begin
            if ($urandom % 2) idle_cycle();
            else if ($urandom % 5 == 0) issue_inst(inst_t'($urandom)); // mostly illegal
            else issue_inst(rand_inst());
        end
    endtask

    initial begin
        i_rst        = 1'b1;
        i_inst       = '0;
        i_inst_valid = 1'b0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        void'($urandom(33));
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst     = 1'b0;
        err_start = errors;
        test_rtype();
        finish_test("r-type alu");
        test_itype();
        finish_test("i-type alu");
        test_chains();
        finish_test("dependent chains");
        test_x0();
        finish_test("x0 writes");
        test_illegal();
        finish_test("illegal encodings");
        test_gaps();
        finish_test("valid gaps");
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
